// ==== build.f ====
+incdir+verilog
verilog/la_id_pkg.sv
verilog/la_inst_decode.sv
verilog/la_ctrl_gen.sv
verilog/la_imm_gen.sv
verilog/la_dec_reg.sv
verilog/la_id_stage.sv
verif/la_id_checker.sv
verif/la_id_tb.sv

// ==== verif/la_id_checker.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_id_checker (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_inst_valid,
  input logic                 o_inst_ready,
  input logic [`LA_XLEN-1:0]  i_inst,
  input logic                 o_dec_valid,
  input logic                 i_dec_ready,
  input logic                 o_reg_write,
  input logic                 o_mem_write,
  input logic                 o_mem_read,
  input logic                 o_alu_src1,
  input logic                 o_alu_src2,
  input logic [1:0]           o_wd_sel,
  input logic [4:0]           o_npc_op,
  input logic [4:0]           o_alu_op,
  input logic [2:0]           o_dm_type,
  input logic [`LA_XLEN-1:0]  o_imm4alu,
  input logic [`LA_XLEN-1:0]  o_imm4pc,
  input logic [`LA_REG_W-1:0] o_rd,
  input logic [`LA_REG_W-1:0] o_rs1,
  input logic [`LA_REG_W-1:0] o_rs2,
  input logic                 o_illegal
);

  int                  fail_cnt = 0;
  logic [`LA_XLEN-1:0] acc_inst;  // last accepted word
  logic [99:0]         out_bus;
  logic                is_addi;
  logic                is_lu12i;
  logic                is_bl;
  logic                is_st_w;
  logic                is_ld_w;
  logic                is_bad;
  logic [`LA_XLEN-1:0] exp_si12;
  logic [`LA_XLEN-1:0] exp_i20;
  logic [`LA_XLEN-1:0] exp_pc26;

  always_ff @(posedge i_clk) begin
    if (i_inst_valid && o_inst_ready) begin
      acc_inst <= i_inst;
    end
  end

  assign out_bus = {o_reg_write, o_mem_write, o_mem_read, o_alu_src1, o_alu_src2, o_wd_sel,
                    o_npc_op, o_alu_op, o_dm_type, o_imm4alu, o_imm4pc, o_rd, o_rs1, o_rs2,
                    o_illegal};

  // LA32R encodings
  assign is_addi  = acc_inst[31:22] == 10'h00a;
  assign is_lu12i = acc_inst[31:25] == 7'h0a;
  assign is_bl    = acc_inst[31:26] == 6'h15;
  assign is_st_w  = acc_inst[31:22] == 10'h0a6;
  assign is_ld_w  = acc_inst[31:22] == 10'h0a2;
  assign is_bad   = acc_inst[31:26] == 6'h3f;

  assign exp_si12 = {{20{acc_inst[21]}}, acc_inst[21:10]};
  assign exp_i20  = {acc_inst[24:5], 12'h000};
  assign exp_pc26 = {{4{acc_inst[9]}}, acc_inst[9:0], acc_inst[25:10], 2'b00}; // offs hi, lo

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  a_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_dec_valid && o_inst_ready)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("o_dec_valid high or o_inst_ready low during or right after reset");
    end

  a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_inst_valid && o_inst_ready |=> o_dec_valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("o_dec_valid not high one cycle after an accepted instruction");
    end

  a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && !i_dec_ready |=> o_dec_valid && $stable(out_bus))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("decoded outputs did not hold while the consumer stalled");
    end

  a_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_inst_ready == (!o_dec_valid || i_dec_ready))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_inst_ready exp %h got %h",
             $sampled(!o_dec_valid || i_dec_ready), $sampled(o_inst_ready));
    end

  ////////////////////////////////////////////////////////////////////////////
  // decoded values
  a_addi_imm: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_addi |-> o_imm4alu == exp_si12)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_imm4alu exp %h got %h", $sampled(exp_si12), $sampled(o_imm4alu));
    end

  a_addi_op: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_addi |-> o_alu_op == `LA_ALU_ADD)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_alu_op exp %h got %h", `LA_ALU_ADD, $sampled(o_alu_op));
    end

  // register plus immediate, falls through to pc + 4
  a_addi_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_addi |-> !o_alu_src1 && o_alu_src2 && o_npc_op == `LA_NPC_PLUS4)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_alu_src1/o_alu_src2/o_npc_op exp 0/1/%h got %h/%h/%h",
             `LA_NPC_PLUS4, $sampled(o_alu_src1), $sampled(o_alu_src2), $sampled(o_npc_op));
    end

  a_lu12i_imm: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_lu12i |-> o_imm4alu == exp_i20)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_imm4alu exp %h got %h", $sampled(exp_i20), $sampled(o_imm4alu));
    end

  a_bl_link: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_bl |-> o_imm4alu == 32'd4 && o_rd == 5'd1)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_imm4alu/o_rd exp 00000004/01 got %h/%h",
             $sampled(o_imm4alu), $sampled(o_rd));
    end

  a_bl_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_bl |-> o_imm4pc == exp_pc26)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_imm4pc exp %h got %h", $sampled(exp_pc26), $sampled(o_imm4pc));
    end

  // link value built from the pc, jump target
  a_bl_ctrl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_bl |-> o_alu_src1 && o_npc_op == `LA_NPC_JUMP)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_alu_src1/o_npc_op exp 1/%h got %h/%h",
             `LA_NPC_JUMP, $sampled(o_alu_src1), $sampled(o_npc_op));
    end

  a_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_st_w |->
      !o_reg_write && o_mem_write && o_rs1 == acc_inst[9:5] && o_rs2 == acc_inst[4:0])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_reg_write/o_mem_write/o_rs1/o_rs2 exp 0/1/%h/%h got %h/%h/%h/%h",
             $sampled(acc_inst[9:5]), $sampled(acc_inst[4:0]), $sampled(o_reg_write),
             $sampled(o_mem_write), $sampled(o_rs1), $sampled(o_rs2));
    end

  a_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_ld_w |->
      o_mem_read && o_wd_sel == `LA_WD_MEM && o_dm_type == `LA_DM_WORD)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_mem_read/o_wd_sel/o_dm_type exp 1/%h/%h got %h/%h/%h",
             `LA_WD_MEM, `LA_DM_WORD, $sampled(o_mem_read), $sampled(o_wd_sel),
             $sampled(o_dm_type));
    end

  a_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && is_bad |-> o_illegal && !o_reg_write && !o_mem_write && !o_mem_read)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("[ERROR] o_illegal/o_reg_write/o_mem_write/o_mem_read exp 1/0/0/0 got %h/%h/%h/%h",
             $sampled(o_illegal), $sampled(o_reg_write), $sampled(o_mem_write),
             $sampled(o_mem_read));
    end

endmodule

bind la_id_stage la_id_checker u_la_id_checker (.*);

// ==== verif/la_id_tb.sv ====
`timescale 1ns/100ps

module la_id_tb;

  localparam int TIMEOUT = 100; // cycles per wait

  logic        i_clk;
  logic        i_rst_n;
  logic        i_inst_valid;
  logic        o_inst_ready;
  logic [31:0] i_inst;
  logic        o_dec_valid;
  logic        i_dec_ready;
  logic        o_reg_write;
  logic        o_mem_write;
  logic        o_mem_read;
  logic        o_alu_src1;
  logic        o_alu_src2;
  logic [1:0]  o_wd_sel;
  logic [4:0]  o_npc_op;
  logic [4:0]  o_alu_op;
  logic [2:0]  o_dm_type;
  logic [31:0] o_imm4alu;
  logic [31:0] o_imm4pc;
  logic [4:0]  o_rd;
  logic [4:0]  o_rs1;
  logic [4:0]  o_rs2;
  logic        o_illegal;

  logic [31:0] lfsr_state;
  int          timeouts;
  int          fails_mark;
  int          timeouts_mark;

  la_id_stage u_la_id_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .o_inst_ready (o_inst_ready),
    .i_inst       (i_inst),
    .o_dec_valid  (o_dec_valid),
    .i_dec_ready  (i_dec_ready),
    .o_reg_write  (o_reg_write),
    .o_mem_write  (o_mem_write),
    .o_mem_read   (o_mem_read),
    .o_alu_src1   (o_alu_src1),
    .o_alu_src2   (o_alu_src2),
    .o_wd_sel     (o_wd_sel),
    .o_npc_op     (o_npc_op),
    .o_alu_op     (o_alu_op),
    .o_dm_type    (o_dm_type),
    .o_imm4alu    (o_imm4alu),
    .o_imm4pc     (o_imm4pc),
    .o_rd         (o_rd),
    .o_rs1        (o_rs1),
    .o_rs2        (o_rs2),
    .o_illegal    (o_illegal)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] make_inst(input int kind, input logic [31:0] r);
    case (kind)
      0:       return {10'h00a, r[21:0]};  // addi.w
      1:       return {7'h0a, r[24:0]};    // lu12i.w
      2:       return {6'h15, r[25:0]};    // bl
      3:       return {10'h0a6, r[21:0]};  // st.w
      4:       return {10'h0a2, r[21:0]};  // ld.w
      default: return {6'h3f, r[25:0]};    // no such opcode
    endcase
  endfunction

  // one edge, then new inputs 1 ns later
  task automatic next_cycle(input logic rand_ready);
    logic [31:0] r;
    @(posedge i_clk);
    #1;
    if (rand_ready) begin
      draw(1, r);
      i_dec_ready = r[0];
    end else begin
      i_dec_ready = 1'b1;
    end
  endtask

  task automatic send_inst(input logic [31:0] inst);
    logic taken;
    int   waited;
    taken        = 1'b0;
    waited       = 0;
    i_inst_valid = 1'b1;
    i_inst       = inst;
    while (!taken && waited < TIMEOUT) begin
      @(negedge i_clk);
      taken = o_inst_ready; // settled mid-cycle
      next_cycle(1'b1);
      waited++;
    end
    i_inst_valid = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("timeout: instruction %h was never accepted", inst);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (o_dec_valid !== 1'b0 && waited < TIMEOUT) begin
      next_cycle(1'b0);
      waited++;
    end
    if (o_dec_valid !== 1'b0) begin
      timeouts++;
      $display("timeout: decoded item was never taken by the consumer");
    end
  endtask

  task automatic report_test(input string name);
    int fails;
    int touts;
    fails = u_la_id_stage.u_la_id_checker.fail_cnt - fails_mark;
    touts = timeouts - timeouts_mark;
    $display("test %-8s %-6s %0d assertion failures, %0d timeouts", name,
             (fails == 0 && touts == 0) ? "ok" : "errors", fails, touts);
    fails_mark    = u_la_id_stage.u_la_id_checker.fail_cnt;
    timeouts_mark = timeouts;
  endtask

  // kind < 0 mixes all kinds
  task automatic run_test(input string name, input int kind, input int count);
    logic [31:0] r;
    logic [31:0] k;
    for (int n = 0; n < count; n++) begin
      draw(26, r);
      if (kind < 0) begin
        draw(3, k);
        send_inst(make_inst(k % 6, r));
      end else begin
        send_inst(make_inst(kind, r));
      end
    end
    drain();
    report_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  initial begin
    i_rst_n       = 1'b0;
    i_inst_valid  = 1'b0;
    i_inst        = '0;
    i_dec_ready   = 1'b1;
    lfsr_state    = 32'h244d;
    timeouts      = 0;
    fails_mark    = 0;
    timeouts_mark = 0;

    repeat (3) next_cycle(1'b0);
    i_rst_n = 1'b1;
    next_cycle(1'b0);  // first edge out of reset
    report_test("reset");

    run_test("addi.w", 0, 12);
    run_test("lu12i.w", 1, 12);
    run_test("bl", 2, 12);
    run_test("st.w", 3, 12);
    run_test("ld.w", 4, 12);
    run_test("illegal", 5, 12);
    run_test("mixed", -1, 48);

    $display("summary: %0d assertion failures, %0d timeouts",
             u_la_id_stage.u_la_id_checker.fail_cnt, timeouts);
    if (u_la_id_stage.u_la_id_checker.fail_cnt == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog/la_consts.svh ====
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

`define LA_XLEN     32
`define LA_REG_W    5
`define LA_NUM_INST 39

// hit vector indices
`define LA_HIT_ADD_W     0
`define LA_HIT_SUB_W     1
`define LA_HIT_SLT       2
`define LA_HIT_SLTU      3
`define LA_HIT_NOR       4
`define LA_HIT_AND       5
`define LA_HIT_OR        6
`define LA_HIT_XOR       7
`define LA_HIT_SLLI_W    8
`define LA_HIT_SRLI_W    9
`define LA_HIT_SRAI_W    10
`define LA_HIT_ADDI_W    11
`define LA_HIT_LD_W      12
`define LA_HIT_ST_W      13
`define LA_HIT_JIRL      14
`define LA_HIT_B         15
`define LA_HIT_BL        16
`define LA_HIT_BEQ       17
`define LA_HIT_BNE       18
`define LA_HIT_LU12I_W   19
`define LA_HIT_SLTI      20
`define LA_HIT_SLTUI     21
`define LA_HIT_ANDI      22
`define LA_HIT_ORI       23
`define LA_HIT_XORI      24
`define LA_HIT_SLL_W     25
`define LA_HIT_SRL_W     26
`define LA_HIT_SRA_W     27
`define LA_HIT_PCADDU12I 28
`define LA_HIT_ST_B      29
`define LA_HIT_ST_H      30
`define LA_HIT_LD_B      31
`define LA_HIT_LD_H      32
`define LA_HIT_LD_HU     33
`define LA_HIT_LD_BU     34
`define LA_HIT_BLT       35
`define LA_HIT_BGE       36
`define LA_HIT_BLTU      37
`define LA_HIT_BGEU      38

// alu operation
`define LA_ALU_NOP   5'd0
`define LA_ALU_LUI   5'd1
`define LA_ALU_AUIPC 5'd2
`define LA_ALU_ADD   5'd3
`define LA_ALU_SUB   5'd4
`define LA_ALU_BNE   5'd5
`define LA_ALU_BLT   5'd6
`define LA_ALU_BGE   5'd7
`define LA_ALU_BLTU  5'd8
`define LA_ALU_BGEU  5'd9
`define LA_ALU_SLT   5'd10
`define LA_ALU_SLTU  5'd11
`define LA_ALU_XOR   5'd12
`define LA_ALU_OR    5'd13
`define LA_ALU_AND   5'd14
`define LA_ALU_SLL   5'd15
`define LA_ALU_SRL   5'd16
`define LA_ALU_SRA   5'd17
`define LA_ALU_NOR   5'd18
`define LA_ALU_BEQ   5'd19

// next pc operation
`define LA_NPC_PLUS4  5'b00000
`define LA_NPC_BRANCH 5'b00001
`define LA_NPC_JUMP   5'b00110
`define LA_NPC_JIRL   5'b11000

// register write data select
`define LA_WD_ALU 2'd0
`define LA_WD_MEM 2'd1
`define LA_WD_PC  2'd2

// data memory access type
`define LA_DM_WORD   3'd0
`define LA_DM_HALF   3'd1
`define LA_DM_HALF_U 3'd2
`define LA_DM_BYTE   3'd3
`define LA_DM_BYTE_U 3'd4

// major opcode match values
`define LA_OP6_ALU       6'h00
`define LA_OP6_LU12I     6'h05
`define LA_OP6_PCADDU12I 6'h07
`define LA_OP6_MEM       6'h0a
`define LA_OP4_3R        4'h0
`define LA_OP4_SHIFTI    4'h1
`define LA_OP2_3R        2'h1

`endif

// ==== verilog/la_ctrl_gen.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_ctrl_gen (
  input  la_id_pkg::la_inst_u     i_inst,
  input  logic [`LA_NUM_INST-1:0] i_hit,
  input  logic                    i_illegal,
  output logic                    o_reg_write,
  output logic                    o_mem_write,
  output logic                    o_mem_read,
  output logic                    o_alu_src1,
  output logic                    o_alu_src2,
  output logic [1:0]              o_wd_sel,
  output logic [4:0]              o_npc_op,
  output logic [4:0]              o_alu_op,
  output logic [2:0]              o_dm_type,
  output logic [`LA_REG_W-1:0]    o_rd,
  output logic [`LA_REG_W-1:0]    o_rs1,
  output logic [`LA_REG_W-1:0]    o_rs2
);

  logic is_load;
  logic is_store;
  logic is_cbr;   // conditional branch
  logic is_add;   // address / link / pc-relative adds
  logic is_shi;

  assign is_load  = i_hit[`LA_HIT_LD_W] | i_hit[`LA_HIT_LD_H] | i_hit[`LA_HIT_LD_HU] |
                    i_hit[`LA_HIT_LD_B] | i_hit[`LA_HIT_LD_BU];
  assign is_store = i_hit[`LA_HIT_ST_W] | i_hit[`LA_HIT_ST_H] | i_hit[`LA_HIT_ST_B];
  assign is_cbr   = i_hit[`LA_HIT_BEQ] | i_hit[`LA_HIT_BNE] | i_hit[`LA_HIT_BLT] |
                    i_hit[`LA_HIT_BGE] | i_hit[`LA_HIT_BLTU] | i_hit[`LA_HIT_BGEU];
  assign is_add   = i_hit[`LA_HIT_ADD_W] | i_hit[`LA_HIT_ADDI_W] | is_load | is_store |
                    i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_B] | i_hit[`LA_HIT_BL] |
                    i_hit[`LA_HIT_PCADDU12I];
  assign is_shi   = i_hit[`LA_HIT_SLLI_W] | i_hit[`LA_HIT_SRLI_W] | i_hit[`LA_HIT_SRAI_W];

  // side effects are killed for an illegal word
  assign o_reg_write = ~(is_store | is_cbr | i_hit[`LA_HIT_B]) & ~i_illegal;
  assign o_mem_write = is_store & ~i_illegal;
  assign o_mem_read  = is_load & ~i_illegal;

  assign o_alu_src1 = i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_BL] | i_hit[`LA_HIT_PCADDU12I];
  assign o_alu_src2 = is_shi | i_hit[`LA_HIT_ADDI_W] | is_load | is_store |
                      i_hit[`LA_HIT_LU12I_W] | i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_BL] |
                      i_hit[`LA_HIT_PCADDU12I] | i_hit[`LA_HIT_SLTI] | i_hit[`LA_HIT_SLTUI] |
                      i_hit[`LA_HIT_ANDI] | i_hit[`LA_HIT_ORI] | i_hit[`LA_HIT_XORI];

  assign o_wd_sel = (i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_BL]) ? `LA_WD_PC  :
                    is_load                                  ? `LA_WD_MEM :
                                                               `LA_WD_ALU;

  assign o_npc_op = i_hit[`LA_HIT_JIRL]                    ? `LA_NPC_JIRL   :
                    (i_hit[`LA_HIT_B] | i_hit[`LA_HIT_BL]) ? `LA_NPC_JUMP   :
                    is_cbr                                 ? `LA_NPC_BRANCH :
                                                             `LA_NPC_PLUS4;

  //////////////////////////////////////////////////////////////////////////
  // alu op, one match per instruction group
  always_comb begin
    o_alu_op = `LA_ALU_NOP;
    if (is_add)                                              o_alu_op = `LA_ALU_ADD;
    if (i_hit[`LA_HIT_LU12I_W])                              o_alu_op = `LA_ALU_LUI;
    if (i_hit[`LA_HIT_SUB_W])                                o_alu_op = `LA_ALU_SUB;
    if (i_hit[`LA_HIT_SLT] | i_hit[`LA_HIT_SLTI])            o_alu_op = `LA_ALU_SLT;
    if (i_hit[`LA_HIT_SLTU] | i_hit[`LA_HIT_SLTUI])          o_alu_op = `LA_ALU_SLTU;
    if (i_hit[`LA_HIT_AND] | i_hit[`LA_HIT_ANDI])            o_alu_op = `LA_ALU_AND;
    if (i_hit[`LA_HIT_OR] | i_hit[`LA_HIT_ORI])              o_alu_op = `LA_ALU_OR;
    if (i_hit[`LA_HIT_XOR] | i_hit[`LA_HIT_XORI])            o_alu_op = `LA_ALU_XOR;
    if (i_hit[`LA_HIT_NOR])                                  o_alu_op = `LA_ALU_NOR;
    if (i_hit[`LA_HIT_SLL_W] | i_hit[`LA_HIT_SLLI_W])        o_alu_op = `LA_ALU_SLL;
    if (i_hit[`LA_HIT_SRL_W] | i_hit[`LA_HIT_SRLI_W])        o_alu_op = `LA_ALU_SRL;
    if (i_hit[`LA_HIT_SRA_W] | i_hit[`LA_HIT_SRAI_W])        o_alu_op = `LA_ALU_SRA;
    if (i_hit[`LA_HIT_BEQ])                                  o_alu_op = `LA_ALU_BEQ;
    if (i_hit[`LA_HIT_BNE])                                  o_alu_op = `LA_ALU_BNE;
    if (i_hit[`LA_HIT_BLT])                                  o_alu_op = `LA_ALU_BLT;
    if (i_hit[`LA_HIT_BGE])                                  o_alu_op = `LA_ALU_BGE;
    if (i_hit[`LA_HIT_BLTU])                                 o_alu_op = `LA_ALU_BLTU;
    if (i_hit[`LA_HIT_BGEU])                                 o_alu_op = `LA_ALU_BGEU;
  end

  // width and sign of the memory access
  always_comb begin
    o_dm_type = `LA_DM_WORD;
    if (i_hit[`LA_HIT_LD_H] | i_hit[`LA_HIT_ST_H]) o_dm_type = `LA_DM_HALF;
    if (i_hit[`LA_HIT_LD_HU])                      o_dm_type = `LA_DM_HALF_U;
    if (i_hit[`LA_HIT_LD_B] | i_hit[`LA_HIT_ST_B]) o_dm_type = `LA_DM_BYTE;
    if (i_hit[`LA_HIT_LD_BU])                      o_dm_type = `LA_DM_BYTE_U;
  end

  assign o_rd  = i_hit[`LA_HIT_BL] ? `LA_REG_W'd1 : i_inst.r3.rd; // bl links to r1
  assign o_rs1 = i_inst.r3.rj;
  assign o_rs2 = (is_store | is_cbr) ? i_inst.r3.rd : i_inst.r3.rk;

endmodule

// ==== verilog/la_dec_reg.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_dec_reg (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  output logic                 o_ready,
  output logic                 o_valid,
  input  logic                 i_ready,
  input  logic                 i_reg_write,
  input  logic                 i_mem_write,
  input  logic                 i_mem_read,
  input  logic                 i_alu_src1,
  input  logic                 i_alu_src2,
  input  logic [1:0]           i_wd_sel,
  input  logic [4:0]           i_npc_op,
  input  logic [4:0]           i_alu_op,
  input  logic [2:0]           i_dm_type,
  input  logic [`LA_XLEN-1:0]  i_imm4alu,
  input  logic [`LA_XLEN-1:0]  i_imm4pc,
  input  logic [`LA_REG_W-1:0] i_rd,
  input  logic [`LA_REG_W-1:0] i_rs1,
  input  logic [`LA_REG_W-1:0] i_rs2,
  input  logic                 i_illegal,
  output logic                 o_reg_write,
  output logic                 o_mem_write,
  output logic                 o_mem_read,
  output logic                 o_alu_src1,
  output logic                 o_alu_src2,
  output logic [1:0]           o_wd_sel,
  output logic [4:0]           o_npc_op,
  output logic [4:0]           o_alu_op,
  output logic [2:0]           o_dm_type,
  output logic [`LA_XLEN-1:0]  o_imm4alu,
  output logic [`LA_XLEN-1:0]  o_imm4pc,
  output logic [`LA_REG_W-1:0] o_rd,
  output logic [`LA_REG_W-1:0] o_rs1,
  output logic [`LA_REG_W-1:0] o_rs2,
  output logic                 o_illegal
);

  logic load;

  assign o_ready = ~o_valid | i_ready; // refill while draining
  assign load    = i_valid & o_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0; // drained, nothing new
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_reg_write <= i_reg_write;
      o_mem_write <= i_mem_write;
      o_mem_read  <= i_mem_read;
      o_alu_src1  <= i_alu_src1;
      o_alu_src2  <= i_alu_src2;
      o_wd_sel    <= i_wd_sel;
      o_npc_op    <= i_npc_op;
      o_alu_op    <= i_alu_op;
      o_dm_type   <= i_dm_type;
      o_imm4alu   <= i_imm4alu;
      o_imm4pc    <= i_imm4pc;
      o_rd        <= i_rd;
      o_rs1       <= i_rs1;
      o_rs2       <= i_rs2;
      o_illegal   <= i_illegal;
    end
  end

endmodule

// ==== verilog/la_id_pkg.sv ====
package la_id_pkg;

  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } la_3r_t;

  typedef struct packed {
    logic [9:0]  opcode;
    logic [11:0] imm12;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } la_2ri12_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [15:0] offs16;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } la_2ri16_t;

  typedef struct packed {
    logic [6:0]  opcode;
    logic [19:0] imm20;
    logic [4:0]  rd;
  } la_1ri20_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [15:0] offs_lo; // offs[15:0]
    logic [9:0]  offs_hi; // offs[25:16]
  } la_i26_t;

  // one word, five views
  typedef union packed {
    la_3r_t    r3;
    la_2ri12_t ri12;
    la_2ri16_t ri16;
    la_1ri20_t ri20;
    la_i26_t   i26;
  } la_inst_u;

endpackage

// ==== verilog/la_id_stage.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_id_stage (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_inst_valid,
  output logic                 o_inst_ready,
  input  logic [`LA_XLEN-1:0]  i_inst,
  output logic                 o_dec_valid,
  input  logic                 i_dec_ready,
  output logic                 o_reg_write,
  output logic                 o_mem_write,
  output logic                 o_mem_read,
  output logic                 o_alu_src1,
  output logic                 o_alu_src2,
  output logic [1:0]           o_wd_sel,
  output logic [4:0]           o_npc_op,
  output logic [4:0]           o_alu_op,
  output logic [2:0]           o_dm_type,
  output logic [`LA_XLEN-1:0]  o_imm4alu,
  output logic [`LA_XLEN-1:0]  o_imm4pc,
  output logic [`LA_REG_W-1:0] o_rd,
  output logic [`LA_REG_W-1:0] o_rs1,
  output logic [`LA_REG_W-1:0] o_rs2,
  output logic                 o_illegal
);

  logic [`LA_NUM_INST-1:0] hit;
  logic                    illegal;
  logic                    reg_write;
  logic                    mem_write;
  logic                    mem_read;
  logic                    alu_src1;
  logic                    alu_src2;
  logic [1:0]              wd_sel;
  logic [4:0]              npc_op;
  logic [4:0]              alu_op;
  logic [2:0]              dm_type;
  logic [`LA_XLEN-1:0]     imm4alu;
  logic [`LA_XLEN-1:0]     imm4pc;
  logic [`LA_REG_W-1:0]    rd;
  logic [`LA_REG_W-1:0]    rs1;
  logic [`LA_REG_W-1:0]    rs2;

  ////////////////////////////////////////////////////////////////////////////
  // combinational decode
  la_inst_decode u_inst_decode (
    .i_inst    (i_inst),
    .o_hit     (hit),
    .o_illegal (illegal)
  );

  la_ctrl_gen u_ctrl_gen (
    .i_inst      (i_inst),
    .i_hit       (hit),
    .i_illegal   (illegal),
    .o_reg_write (reg_write),
    .o_mem_write (mem_write),
    .o_mem_read  (mem_read),
    .o_alu_src1  (alu_src1),
    .o_alu_src2  (alu_src2),
    .o_wd_sel    (wd_sel),
    .o_npc_op    (npc_op),
    .o_alu_op    (alu_op),
    .o_dm_type   (dm_type),
    .o_rd        (rd),
    .o_rs1       (rs1),
    .o_rs2       (rs2)
  );

  la_imm_gen u_imm_gen (
    .i_inst    (i_inst),
    .i_hit     (hit),
    .o_imm4alu (imm4alu),
    .o_imm4pc  (imm4pc)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output slice, owns both handshakes
  la_dec_reg u_dec_reg (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_inst_valid),
    .o_ready     (o_inst_ready),
    .o_valid     (o_dec_valid),
    .i_ready     (i_dec_ready),
    .i_reg_write (reg_write),
    .i_mem_write (mem_write),
    .i_mem_read  (mem_read),
    .i_alu_src1  (alu_src1),
    .i_alu_src2  (alu_src2),
    .i_wd_sel    (wd_sel),
    .i_npc_op    (npc_op),
    .i_alu_op    (alu_op),
    .i_dm_type   (dm_type),
    .i_imm4alu   (imm4alu),
    .i_imm4pc    (imm4pc),
    .i_rd        (rd),
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_illegal   (illegal),
    .o_reg_write (o_reg_write),
    .o_mem_write (o_mem_write),
    .o_mem_read  (o_mem_read),
    .o_alu_src1  (o_alu_src1),
    .o_alu_src2  (o_alu_src2),
    .o_wd_sel    (o_wd_sel),
    .o_npc_op    (o_npc_op),
    .o_alu_op    (o_alu_op),
    .o_dm_type   (o_dm_type),
    .o_imm4alu   (o_imm4alu),
    .o_imm4pc    (o_imm4pc),
    .o_rd        (o_rd),
    .o_rs1       (o_rs1),
    .o_rs2       (o_rs2),
    .o_illegal   (o_illegal)
  );

endmodule

// ==== verilog/la_imm_gen.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_imm_gen (
  input  la_id_pkg::la_inst_u     i_inst,
  input  logic [`LA_NUM_INST-1:0] i_hit,
  output logic [`LA_XLEN-1:0]     o_imm4alu,
  output logic [`LA_XLEN-1:0]     o_imm4pc
);

  logic [25:0]         i26;
  logic [`LA_XLEN-1:0] offs16_x;  // sign-extended, word offset
  logic [`LA_XLEN-1:0] offs26_x;
  logic                need_4;
  logic                need_i20;
  logic                need_si16;
  logic                need_si26;
  logic                need_ui5;
  logic                need_ui12;

  assign i26      = {i_inst.i26.offs_hi, i_inst.i26.offs_lo};
  assign offs16_x = {{14{i_inst.ri16.offs16[15]}}, i_inst.ri16.offs16, 2'b00};
  assign offs26_x = {{4{i26[25]}}, i26, 2'b00};

  assign need_4    = i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_BL]; // link address pc + 4
  assign need_i20  = i_hit[`LA_HIT_LU12I_W] | i_hit[`LA_HIT_PCADDU12I];
  assign need_si16 = i_hit[`LA_HIT_JIRL] | i_hit[`LA_HIT_BEQ] | i_hit[`LA_HIT_BNE] |
                     i_hit[`LA_HIT_BLT] | i_hit[`LA_HIT_BGE] | i_hit[`LA_HIT_BLTU] |
                     i_hit[`LA_HIT_BGEU];
  assign need_si26 = i_hit[`LA_HIT_B] | i_hit[`LA_HIT_BL];
  assign need_ui5  = i_hit[`LA_HIT_SLLI_W] | i_hit[`LA_HIT_SRLI_W] | i_hit[`LA_HIT_SRAI_W];
  assign need_ui12 = i_hit[`LA_HIT_ANDI] | i_hit[`LA_HIT_ORI] | i_hit[`LA_HIT_XORI];

  assign o_imm4alu = need_4    ? `LA_XLEN'd4                                :
                     need_i20  ? {i_inst.ri20.imm20, 12'b0}                 :
                     need_si16 ? offs16_x                                   :
                     need_si26 ? offs26_x                                   :
                     need_ui5  ? {27'b0, i_inst.r3.rk}                      :
                     need_ui12 ? {20'b0, i_inst.ri12.imm12}                 :
                                 {{20{i_inst.ri12.imm12[11]}}, i_inst.ri12.imm12};

  assign o_imm4pc = need_si26 ? offs26_x :
                    need_si16 ? offs16_x :
                                '0;

endmodule

// ==== verilog/la_inst_decode.sv ====
`timescale 1ns/100ps
`include "la_consts.svh"

module la_inst_decode (
  input  la_id_pkg::la_inst_u     i_inst,
  output logic [`LA_NUM_INST-1:0] o_hit,
  output logic                    o_illegal
);

  logic [5:0]  op_31_26;
  logic [3:0]  op_25_22;
  logic [1:0]  op_21_20;
  logic [4:0]  op_19_15;
  logic [63:0] d6;
  logic [15:0] d4;
  logic [3:0]  d2;
  logic [31:0] d5;
  logic        r3_grp;
  logic        shi_grp;

  // 3r opcode spans bits 31:15
  assign op_31_26 = i_inst.r3.opcode[16:11];
  assign op_25_22 = i_inst.r3.opcode[10:7];
  assign op_21_20 = i_inst.r3.opcode[6:5];
  assign op_19_15 = i_inst.r3.opcode[4:0];

  assign d6 = 64'd1 << op_31_26;
  assign d4 = 16'd1 << op_25_22;
  assign d2 = 4'd1 << op_21_20;
  assign d5 = 32'd1 << op_19_15;

  assign r3_grp  = d6[`LA_OP6_ALU] & d4[`LA_OP4_3R] & d2[`LA_OP2_3R];
  assign shi_grp = d6[`LA_OP6_ALU] & d4[`LA_OP4_SHIFTI] & d2[2'h0];

  //////////////////////////////////////////////////////////////////////////
  // register-register
  assign o_hit[`LA_HIT_ADD_W]  = r3_grp & d5[5'h00];
  assign o_hit[`LA_HIT_SUB_W]  = r3_grp & d5[5'h02];
  assign o_hit[`LA_HIT_SLT]    = r3_grp & d5[5'h04];
  assign o_hit[`LA_HIT_SLTU]   = r3_grp & d5[5'h05];
  assign o_hit[`LA_HIT_NOR]    = r3_grp & d5[5'h08];
  assign o_hit[`LA_HIT_AND]    = r3_grp & d5[5'h09];
  assign o_hit[`LA_HIT_OR]     = r3_grp & d5[5'h0a];
  assign o_hit[`LA_HIT_XOR]    = r3_grp & d5[5'h0b];
  assign o_hit[`LA_HIT_SLL_W]  = r3_grp & d5[5'h0e];
  assign o_hit[`LA_HIT_SRL_W]  = r3_grp & d5[5'h0f];
  assign o_hit[`LA_HIT_SRA_W]  = r3_grp & d5[5'h10];
  assign o_hit[`LA_HIT_SLLI_W] = shi_grp & d5[5'h01];
  assign o_hit[`LA_HIT_SRLI_W] = shi_grp & d5[5'h09];
  assign o_hit[`LA_HIT_SRAI_W] = shi_grp & d5[5'h11];

  // 12-bit immediate arithmetic
  assign o_hit[`LA_HIT_SLTI]   = d6[`LA_OP6_ALU] & d4[4'h8];
  assign o_hit[`LA_HIT_SLTUI]  = d6[`LA_OP6_ALU] & d4[4'h9];
  assign o_hit[`LA_HIT_ADDI_W] = d6[`LA_OP6_ALU] & d4[4'ha];
  assign o_hit[`LA_HIT_ANDI]   = d6[`LA_OP6_ALU] & d4[4'hd];
  assign o_hit[`LA_HIT_ORI]    = d6[`LA_OP6_ALU] & d4[4'he];
  assign o_hit[`LA_HIT_XORI]   = d6[`LA_OP6_ALU] & d4[4'hf];

  // 20-bit upper immediate, bit 25 must be clear
  assign o_hit[`LA_HIT_LU12I_W]   = d6[`LA_OP6_LU12I] & ~i_inst.ri20.opcode[0];
  assign o_hit[`LA_HIT_PCADDU12I] = d6[`LA_OP6_PCADDU12I] & ~i_inst.ri20.opcode[0];

  //////////////////////////////////////////////////////////////////////////
  // loads and stores
  assign o_hit[`LA_HIT_LD_B]  = d6[`LA_OP6_MEM] & d4[4'h0];
  assign o_hit[`LA_HIT_LD_H]  = d6[`LA_OP6_MEM] & d4[4'h1];
  assign o_hit[`LA_HIT_LD_W]  = d6[`LA_OP6_MEM] & d4[4'h2];
  assign o_hit[`LA_HIT_ST_B]  = d6[`LA_OP6_MEM] & d4[4'h4];
  assign o_hit[`LA_HIT_ST_H]  = d6[`LA_OP6_MEM] & d4[4'h5];
  assign o_hit[`LA_HIT_ST_W]  = d6[`LA_OP6_MEM] & d4[4'h6];
  assign o_hit[`LA_HIT_LD_BU] = d6[`LA_OP6_MEM] & d4[4'h8];
  assign o_hit[`LA_HIT_LD_HU] = d6[`LA_OP6_MEM] & d4[4'h9];

  // jumps and branches, major opcode only
  assign o_hit[`LA_HIT_JIRL] = d6[6'h13];
  assign o_hit[`LA_HIT_B]    = d6[6'h14];
  assign o_hit[`LA_HIT_BL]   = d6[6'h15];
  assign o_hit[`LA_HIT_BEQ]  = d6[6'h16];
  assign o_hit[`LA_HIT_BNE]  = d6[6'h17];
  assign o_hit[`LA_HIT_BLT]  = d6[6'h18];
  assign o_hit[`LA_HIT_BGE]  = d6[6'h19];
  assign o_hit[`LA_HIT_BLTU] = d6[6'h1a];
  assign o_hit[`LA_HIT_BGEU] = d6[6'h1b];

  assign o_illegal = ~|o_hit; // nothing matched

endmodule
